//--- hw/ipic_bus_pkg.sv
package ipic_bus_pkg;

    // ------------------------------------------------------------
    // IPIC bus widths
    // ------------------------------------------------------------

    // Byte address on the bus
    typedef logic [31:0] addr_t;

    // One bus word
    typedef logic [31:0] data_t;

    // Transfer length in bytes
    typedef logic [11:0] length_t;

    // Byte enables of one word
    typedef logic [3:0] be_t;

    // ------------------------------------------------------------
    // Beat geometry
    // ------------------------------------------------------------

    // Bytes carried by one beat, burst beats = length / this
    localparam int bytes_per_beat = 4;

endpackage

//--- hw/ipic_cmd_pkg.sv
package ipic_cmd_pkg;

    // Transaction kinds as requested by tc and dp
    typedef enum logic [1:0] {
        burst_rd  = 2'd0,
        burst_wr  = 2'd1,
        single_rd = 2'd2,
        single_wr = 2'd3
    } cmd_kind_t;

    // Requester that owns the engine
    typedef enum logic {
        req_tc = 1'b0,
        req_dp = 1'b1
    } requester_t;

    // Command sequencer FSM
    typedef enum logic [2:0] {
        seq_idle     = 3'd0,
        seq_request  = 3'd1,
        seq_data     = 3'd2,
        seq_complete = 3'd3
    } seq_state_t;

    // Request arbiter FSM
    typedef enum logic [1:0] {
        arb_idle   = 2'd0,
        arb_busy   = 2'd1,
        arb_finish = 2'd2
    } arb_state_t;

endpackage

//--- hw/ipic_request_arbiter.sv
`timescale 1ns/1ps

module ipic_request_arbiter (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    start_tc,
    input  logic                    start_dp,
    input  ipic_cmd_pkg::cmd_kind_t kind_tc,
    input  ipic_cmd_pkg::cmd_kind_t kind_dp,
    input  ipic_bus_pkg::addr_t     addr_tc,
    input  ipic_bus_pkg::addr_t     addr_dp,
    input  ipic_bus_pkg::length_t   length_tc,
    input  ipic_bus_pkg::length_t   length_dp,
    input  ipic_bus_pkg::data_t     wdata_tc,
    input  ipic_bus_pkg::data_t     wdata_dp,
    output logic                    ack_tc,
    output logic                    ack_dp,
    output logic                    done_tc,
    output logic                    done_dp,
    input  logic                    cmd_done,
    output logic                    cmd_valid,
    output ipic_cmd_pkg::cmd_kind_t cmd_kind,
    output ipic_bus_pkg::addr_t     cmd_addr,
    output ipic_bus_pkg::length_t   cmd_length,
    output ipic_bus_pkg::data_t     cmd_wdata
);
    import ipic_bus_pkg::*;
    import ipic_cmd_pkg::*;

    arb_state_t state;
    requester_t owner;
    requester_t winner;
    cmd_kind_t  sel_kind;
    addr_t      sel_addr;
    length_t    sel_length;
    data_t      sel_wdata;

    // Fixed priority, tc beats dp
    assign winner     = start_tc ? req_tc : req_dp;
    assign sel_kind   = start_tc ? kind_tc : kind_dp;
    assign sel_addr   = start_tc ? addr_tc : addr_dp;
    assign sel_length = start_tc ? length_tc : length_dp;
    assign sel_wdata  = start_tc ? wdata_tc : wdata_dp;

    // Request latch, no reset needed on payload
    always_ff @(posedge clk) begin
        if (state == arb_idle && (start_tc || start_dp)) begin
            owner      <= winner;
            cmd_kind   <= sel_kind;
            cmd_addr   <= sel_addr;
            cmd_length <= sel_length;
            cmd_wdata  <= sel_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state     <= arb_idle;
            ack_tc    <= 1'b0;
            ack_dp    <= 1'b0;
            done_tc   <= 1'b0;
            done_dp   <= 1'b0;
            cmd_valid <= 1'b0;
        end else begin
            case (state)
                arb_idle: begin
                    if (start_tc || start_dp) begin
                        ack_tc    <= (winner == req_tc);
                        ack_dp    <= (winner == req_dp);
                        cmd_valid <= 1'b1;
                        state     <= arb_busy;
                    end
                end
                arb_busy: begin
                    ack_tc    <= 1'b0;
                    ack_dp    <= 1'b0;
                    cmd_valid <= 1'b0;
                    // Route done back to whoever was acked
                    if (cmd_done) begin
                        done_tc <= (owner == req_tc);
                        done_dp <= (owner == req_dp);
                        state   <= arb_finish;
                    end
                end
                arb_finish: begin
                    done_tc <= 1'b0;
                    done_dp <= 1'b0;
                    state   <= arb_idle;
                end
                default: begin
                    state <= arb_idle;
                end
            endcase
        end
    end

endmodule

//--- hw/ipic_command_sequencer.sv
`timescale 1ns/1ps

module ipic_command_sequencer (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    cmd_valid,
    input  ipic_cmd_pkg::cmd_kind_t cmd_kind,
    input  ipic_bus_pkg::addr_t     cmd_addr,
    input  ipic_bus_pkg::length_t   cmd_length,
    output logic                    cmd_done,
    input  logic                    cmd_ack,
    input  logic                    cmplt,
    output logic                    rd_req,
    output logic                    wr_req,
    output ipic_bus_pkg::addr_t     mst_addr,
    output ipic_bus_pkg::length_t   mst_length,
    output ipic_bus_pkg::be_t       mst_be,
    output logic                    mst_type,
    input  logic                    rd_data_done,
    input  logic                    wr_data_done,
    output logic                    rd_start,
    output logic                    wr_start,
    output logic                    burst,
    output ipic_bus_pkg::length_t   xfer_length
);
    import ipic_bus_pkg::*;
    import ipic_cmd_pkg::*;

    localparam be_t be_all = '1;

    seq_state_t state;
    logic       is_write;
    logic       is_burst;
    logic       data_done;
    logic       data_seen;
    logic       cmplt_seen;

    // Kind decode
    assign is_write = (cmd_kind == burst_wr) || (cmd_kind == single_wr);
    assign is_burst = (cmd_kind == burst_rd) || (cmd_kind == burst_wr);

    // Only one data module is active per transaction
    assign data_done = rd_data_done | wr_data_done;

    // Whole words only
    assign mst_be = be_all;

    // Command fields held through the transaction
    always_ff @(posedge clk) begin
        if (state == seq_idle && cmd_valid) begin
            mst_addr    <= cmd_addr;
            mst_length  <= cmd_length;
            mst_type    <= is_burst;
            burst       <= is_burst;
            xfer_length <= cmd_length;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state      <= seq_idle;
            rd_req     <= 1'b0;
            wr_req     <= 1'b0;
            rd_start   <= 1'b0;
            wr_start   <= 1'b0;
            cmd_done   <= 1'b0;
            data_seen  <= 1'b0;
            cmplt_seen <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            rd_start <= 1'b0;
            wr_start <= 1'b0;
            case (state)
                seq_idle: begin
                    if (cmd_valid) begin
                        rd_req     <= !is_write;
                        wr_req     <= is_write;
                        rd_start   <= !is_write;
                        wr_start   <= is_write;
                        data_seen  <= 1'b0;
                        cmplt_seen <= 1'b0;
                        state      <= seq_request;
                    end
                end
                // --------------------------------------------------------
                // Command phase
                // --------------------------------------------------------
                seq_request: begin
                    // Data may already finish before the slave acks
                    data_seen <= data_seen | data_done;
                    if (cmd_ack) begin
                        rd_req <= 1'b0;
                        wr_req <= 1'b0;
                        state  <= (data_seen || data_done) ? seq_complete : seq_data;
                    end
                end
                // --------------------------------------------------------
                // Data phase and completion
                // --------------------------------------------------------
                seq_data: begin
                    cmplt_seen <= cmplt_seen | cmplt;
                    if (data_done) begin
                        if (cmplt_seen || cmplt) begin
                            cmd_done <= 1'b1;
                            state    <= seq_idle;
                        end else begin
                            state <= seq_complete;
                        end
                    end
                end
                seq_complete: begin
                    if (cmplt_seen || cmplt) begin
                        cmd_done <= 1'b1;
                        state    <= seq_idle;
                    end
                end
                default: begin
                    state <= seq_idle;
                end
            endcase
        end
    end

endmodule

//--- hw/ipic_read_receiver.sv
`timescale 1ns/1ps

module ipic_read_receiver #(
    parameter int buf_addr_width = 9
) (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        rd_start,
    input  logic                        burst,
    input  ipic_bus_pkg::length_t       xfer_length,
    input  ipic_bus_pkg::data_t         rd_d,
    input  logic                        rd_src_rdy_n,
    output logic                        rd_dst_rdy_n,
    output logic                        rd_data_done,
    output ipic_bus_pkg::data_t         single_read_data,
    output logic                        rcv_buf_we,
    output logic [buf_addr_width-1:0]   rcv_buf_addr,
    output ipic_bus_pkg::data_t         rcv_buf_din
);
    import ipic_bus_pkg::*;

    length_t beat_count;
    length_t beat_last;
    length_t beat_cnt;
    logic    is_burst;
    logic    accept;

    assign beat_count = length_t'(xfer_length / bytes_per_beat);
    assign accept     = !rd_dst_rdy_n && !rd_src_rdy_n;

    // Beat data and buffer port
    always_ff @(posedge clk) begin
        if (rd_start) begin
            is_burst  <= burst;
            beat_last <= burst ? beat_count - length_t'(1) : '0;
        end
        if (accept) begin
            if (is_burst) begin
                rcv_buf_addr <= beat_cnt[buf_addr_width-1:0];
                rcv_buf_din  <= rd_d;
            end else begin
                single_read_data <= rd_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rd_dst_rdy_n <= 1'b1;
            rd_data_done <= 1'b0;
            rcv_buf_we   <= 1'b0;
            beat_cnt     <= '0;
        end else begin
            rd_data_done <= 1'b0;
            rcv_buf_we   <= accept && is_burst;
            if (rd_start) begin
                rd_dst_rdy_n <= 1'b0;
                beat_cnt     <= '0;
            end else if (accept) begin
                beat_cnt <= beat_cnt + length_t'(1);
                // Last beat closes the channel
                if (beat_cnt == beat_last) begin
                    rd_dst_rdy_n <= 1'b1;
                    rd_data_done <= 1'b1;
                end
            end
        end
    end

endmodule

//--- hw/ipic_write_sender.sv
`timescale 1ns/1ps

module ipic_write_sender #(
    parameter int buf_addr_width = 9
) (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        wr_start,
    input  logic                        burst,
    input  ipic_bus_pkg::length_t       xfer_length,
    input  ipic_bus_pkg::data_t         cmd_wdata,
    input  ipic_bus_pkg::data_t         send_buf_dout,
    input  logic                        wr_dst_rdy_n,
    output logic [buf_addr_width-1:0]   send_buf_addr,
    output ipic_bus_pkg::data_t         wr_d,
    output logic                        wr_sof_n,
    output logic                        wr_eof_n,
    output logic                        wr_src_rdy_n,
    output logic                        wr_data_done
);
    import ipic_bus_pkg::*;

    length_t beat_count;
    length_t beat_last;
    length_t beat_cnt;
    length_t next_cnt;
    logic    is_burst;
    logic    prefetch;
    logic    accept;

    assign beat_count = length_t'(xfer_length / bytes_per_beat);
    assign next_cnt   = beat_cnt + length_t'(1);
    assign accept     = !wr_src_rdy_n && !wr_dst_rdy_n;

    // Look ahead one index on accept so the buffer output
    // already holds the next beat in the following cycle
    assign send_buf_addr = accept ? next_cnt[buf_addr_width-1:0]
                                  : beat_cnt[buf_addr_width-1:0];

    assign wr_d = is_burst ? send_buf_dout : cmd_wdata;

    always_ff @(posedge clk) begin
        if (wr_start) begin
            is_burst  <= burst;
            beat_last <= burst ? beat_count - length_t'(1) : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            prefetch     <= 1'b0;
            wr_src_rdy_n <= 1'b1;
            wr_sof_n     <= 1'b1;
            wr_eof_n     <= 1'b1;
            wr_data_done <= 1'b0;
            beat_cnt     <= '0;
        end else begin
            wr_data_done <= 1'b0;
            if (wr_start) begin
                prefetch <= 1'b1;
                beat_cnt <= '0;
            end else if (prefetch) begin
                // Buffer word 0 is valid from here on
                prefetch     <= 1'b0;
                wr_src_rdy_n <= 1'b0;
                wr_sof_n     <= 1'b0;
                wr_eof_n     <= (beat_last != '0);
            end else if (accept) begin
                wr_sof_n <= 1'b1;
                beat_cnt <= next_cnt;
                if (beat_cnt == beat_last) begin
                    wr_src_rdy_n <= 1'b1;
                    wr_eof_n     <= 1'b1;
                    wr_data_done <= 1'b1;
                end else begin
                    wr_eof_n <= (next_cnt != beat_last);
                end
            end
        end
    end

endmodule

//--- hw/ipic_master.sv
`timescale 1ns/1ps

module ipic_master #(
    parameter int buf_addr_width = 9
) (
    input  logic                        clk,
    input  logic                        reset_n,
    // Requesters
    input  logic                        start_tc,
    input  logic                        start_dp,
    input  ipic_cmd_pkg::cmd_kind_t     kind_tc,
    input  ipic_cmd_pkg::cmd_kind_t     kind_dp,
    input  ipic_bus_pkg::addr_t         addr_tc,
    input  ipic_bus_pkg::addr_t         addr_dp,
    input  ipic_bus_pkg::length_t       length_tc,
    input  ipic_bus_pkg::length_t       length_dp,
    input  ipic_bus_pkg::data_t         wdata_tc,
    input  ipic_bus_pkg::data_t         wdata_dp,
    output logic                        ack_tc,
    output logic                        ack_dp,
    output logic                        done_tc,
    output logic                        done_dp,
    output ipic_bus_pkg::data_t         single_read_data,
    // IPIC command
    output logic                        rd_req,
    output logic                        wr_req,
    output ipic_bus_pkg::addr_t         mst_addr,
    output ipic_bus_pkg::length_t       mst_length,
    output ipic_bus_pkg::be_t           mst_be,
    output logic                        mst_type,
    input  logic                        cmd_ack,
    input  logic                        cmplt,
    // LocalLink read
    input  ipic_bus_pkg::data_t         rd_d,
    input  logic                        rd_src_rdy_n,
    output logic                        rd_dst_rdy_n,
    // LocalLink write
    output ipic_bus_pkg::data_t         wr_d,
    output logic                        wr_sof_n,
    output logic                        wr_eof_n,
    output logic                        wr_src_rdy_n,
    input  logic                        wr_dst_rdy_n,
    // Buffers
    output logic                        rcv_buf_we,
    output logic [buf_addr_width-1:0]   rcv_buf_addr,
    output ipic_bus_pkg::data_t         rcv_buf_din,
    output logic [buf_addr_width-1:0]   send_buf_addr,
    input  ipic_bus_pkg::data_t         send_buf_dout
);
    import ipic_bus_pkg::*;

    // Arbiter to sequencer
    logic                    cmd_valid;
    logic                    cmd_done;
    ipic_cmd_pkg::cmd_kind_t cmd_kind;
    addr_t                   cmd_addr;
    length_t                 cmd_length;
    data_t                   cmd_wdata;

    // Sequencer to data modules
    logic                    rd_start;
    logic                    wr_start;
    logic                    burst;
    length_t                 xfer_length;
    logic                    rd_data_done;
    logic                    wr_data_done;

    ipic_request_arbiter u_arbiter (.*);

    ipic_command_sequencer u_sequencer (.*);

    ipic_read_receiver #(
        .buf_addr_width(buf_addr_width)
    ) u_receiver (.*);

    ipic_write_sender #(
        .buf_addr_width(buf_addr_width)
    ) u_sender (.*);

endmodule

//--- tests/ipic_slave_model.sv
`timescale 1ns/1ps

module ipic_slave_model #(
    parameter int buf_addr_width = 9
) (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        stall_en,
    input  logic                        rd_req,
    input  logic                        wr_req,
    input  ipic_bus_pkg::addr_t         mst_addr,
    input  ipic_bus_pkg::length_t       mst_length,
    input  logic                        mst_type,
    output logic                        cmd_ack,
    output logic                        cmplt,
    output ipic_bus_pkg::data_t         rd_d,
    output logic                        rd_src_rdy_n,
    input  logic                        rd_dst_rdy_n,
    input  ipic_bus_pkg::data_t         wr_d,
    input  logic                        wr_src_rdy_n,
    output logic                        wr_dst_rdy_n,
    input  logic                        rcv_buf_we,
    input  logic [buf_addr_width-1:0]   rcv_buf_addr,
    input  ipic_bus_pkg::data_t         rcv_buf_din,
    input  logic [buf_addr_width-1:0]   send_buf_addr,
    output ipic_bus_pkg::data_t         send_buf_dout
);
    import ipic_bus_pkg::*;

    localparam logic [31:0] seed_init = 32'h5592_374b;

    data_t mem [256];
    data_t rcv_mem [2**buf_addr_width];
    data_t send_mem [2**buf_addr_width];

    integer                    seed;
    logic                      active;
    logic                      is_write;
    logic [7:0]                base;
    logic [7:0]                word_idx;
    length_t                   beats;
    length_t                   beat;
    logic [buf_addr_width-1:0] send_addr_q;

    assign word_idx = base + beat[7:0];

    // Go or stall for one handshake, always go when stalls are off
    function automatic logic random_go();
        return !stall_en || (($random(seed) & 3) != 0);
    endfunction

    initial begin
        seed = seed_init;
        for (int i = 0; i < 256; i++) begin
            mem[i] = seed_init ^ (i * 32'h9e37_79b9);
        end
        for (int i = 0; i < 2**buf_addr_width; i++) begin
            send_mem[i] = 32'ha5a5_0000 + i * 32'h0001_0003;
            rcv_mem[i]  = '0;
        end
        active        = 1'b0;
        cmd_ack       = 1'b0;
        cmplt         = 1'b0;
        rd_d          = '0;
        rd_src_rdy_n  = 1'b1;
        wr_dst_rdy_n  = 1'b1;
        send_buf_dout = '0;
    end

    // ------------------------------------------------------------
    // Handshakes and buffer writes on the rising edge
    // ------------------------------------------------------------
    always @(posedge clk) begin
        send_addr_q <= send_buf_addr;
        if (rcv_buf_we) begin
            rcv_mem[rcv_buf_addr] <= rcv_buf_din;
        end
        if (!reset_n) begin
            active <= 1'b0;
        end else if (!active) begin
            if ((rd_req || wr_req) && cmd_ack) begin
                active   <= 1'b1;
                is_write <= wr_req;
                base     <= mst_addr[9:2];
                beats    <= mst_type ? length_t'(mst_length / bytes_per_beat) : length_t'(1);
                beat     <= '0;
            end
        end else begin
            if (!rd_src_rdy_n && !rd_dst_rdy_n) begin
                beat <= beat + length_t'(1);
            end
            if (!wr_src_rdy_n && !wr_dst_rdy_n) begin
                mem[word_idx] <= wr_d;
                beat          <= beat + length_t'(1);
            end
            if (cmplt) begin
                active <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // Slave outputs change on the falling edge
    // ------------------------------------------------------------
    always @(negedge clk) begin
        send_buf_dout <= send_mem[send_addr_q];
        if (!reset_n) begin
            cmd_ack      <= 1'b0;
            cmplt        <= 1'b0;
            rd_src_rdy_n <= 1'b1;
            wr_dst_rdy_n <= 1'b1;
        end else begin
            cmd_ack      <= (rd_req || wr_req) && !active && random_go();
            rd_src_rdy_n <= !(active && !is_write && beat < beats && random_go());
            wr_dst_rdy_n <= !(active && is_write && beat < beats && random_go());
            // Completion once every beat has moved
            cmplt        <= active && beat == beats && random_go();
            rd_d         <= mem[word_idx];
        end
    end

endmodule

//--- tests/tb_ipic_master.sv
`timescale 1ns/1ps

module tb_ipic_master;
    import ipic_bus_pkg::*;
    import ipic_cmd_pkg::*;

    localparam int buf_addr_width = 9;
    localparam int wait_limit     = 2000;

    logic                      clk;
    logic                      reset_n;
    logic                      stall_en;
    logic                      start_tc, start_dp;
    cmd_kind_t                 kind_tc, kind_dp;
    addr_t                     addr_tc, addr_dp;
    length_t                   length_tc, length_dp;
    data_t                     wdata_tc, wdata_dp;
    logic                      ack_tc, ack_dp, done_tc, done_dp;
    data_t                     single_read_data;
    logic                      rd_req, wr_req, mst_type, cmd_ack, cmplt;
    addr_t                     mst_addr;
    length_t                   mst_length;
    be_t                       mst_be;
    data_t                     rd_d, wr_d, rcv_buf_din, send_buf_dout;
    logic                      rd_src_rdy_n, rd_dst_rdy_n;
    logic                      wr_sof_n, wr_eof_n, wr_src_rdy_n, wr_dst_rdy_n;
    logic                      rcv_buf_we;
    logic [buf_addr_width-1:0] rcv_buf_addr, send_buf_addr;

    length_t wr_beats_exp;
    length_t wr_beat_idx;
    logic    accept_wr;

    ipic_master #(.buf_addr_width(buf_addr_width)) i_dut (.*);

    ipic_slave_model #(.buf_addr_width(buf_addr_width)) u_slave (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED %s got 0x%08h expected 0x%08h",
                                    name, got, exp));
        end
    endtask

    // ------------------------------------------------------------
    // Handshake rules
    // ------------------------------------------------------------
    assign accept_wr = !wr_src_rdy_n && !wr_dst_rdy_n;

    // Index of the write beat on the bus
    always @(posedge clk) begin
        if (!reset_n) begin
            wr_beat_idx <= '0;
        end else if (accept_wr) begin
            wr_beat_idx <= (wr_beat_idx == wr_beats_exp - 1) ? '0 : wr_beat_idx + 1;
        end
    end

    req_held: assert property (@(posedge clk) disable iff (!reset_n)
        (rd_req || wr_req) && !cmd_ack |=> $stable({rd_req, wr_req, mst_addr, mst_length}))
        else stop_on_error("command request changed before cmd_ack");

    req_drop: assert property (@(posedge clk) disable iff (!reset_n)
        (rd_req || wr_req) && cmd_ack |=> !rd_req && !wr_req)
        else stop_on_error("command request still high after cmd_ack");

    be_full: assert property (@(posedge clk) disable iff (!reset_n)
        (rd_req || wr_req) |-> mst_be == 4'hf)
        else stop_on_error($sformatf("CHECK FAILED mst_be got 0x%h expected 0xf", mst_be));

    sof_first: assert property (@(posedge clk) disable iff (!reset_n)
        accept_wr |-> (wr_sof_n == (wr_beat_idx != 0)))
        else stop_on_error("wr_sof_n does not mark only the first write beat");

    eof_last: assert property (@(posedge clk) disable iff (!reset_n)
        accept_wr |-> (wr_eof_n == (wr_beat_idx != wr_beats_exp - 1)))
        else stop_on_error("wr_eof_n does not mark only the last write beat");

    wr_stable: assert property (@(posedge clk) disable iff (!reset_n)
        !wr_src_rdy_n && wr_dst_rdy_n |=> !wr_src_rdy_n && $stable({wr_d, wr_sof_n, wr_eof_n}))
        else stop_on_error("write beat changed while the slave stalled");

    // ------------------------------------------------------------
    // Requester tasks start and end on a falling edge
    // ------------------------------------------------------------
    task automatic drive_request(input requester_t who, input cmd_kind_t kind,
                                 input addr_t addr, input length_t length, input data_t wdata);
        if (who == req_tc) begin
            start_tc  = 1'b1;
            kind_tc   = kind;
            addr_tc   = addr;
            length_tc = length;
            wdata_tc  = wdata;
        end else begin
            start_dp  = 1'b1;
            kind_dp   = kind;
            addr_dp   = addr;
            length_dp = length;
            wdata_dp  = wdata;
        end
    endtask

    task automatic wait_ack(input requester_t who);
        logic seen;
        logic other;
        int   cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen) begin
            @(negedge clk);
            seen  = (who == req_tc) ? ack_tc : ack_dp;
            other = (who == req_tc) ? ack_dp : ack_tc;
            cycles++;
            if (other) begin
                stop_on_error("ack went to the wrong requester");
            end
            if (!seen && cycles >= wait_limit) begin
                stop_on_error("timeout waiting for ack");
            end
        end
        if (who == req_tc) begin
            start_tc = 1'b0;
        end else begin
            start_dp = 1'b0;
        end
    endtask

    task automatic wait_done(input requester_t who);
        logic seen;
        logic other;
        int   cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen) begin
            @(negedge clk);
            seen  = (who == req_tc) ? done_tc : done_dp;
            other = (who == req_tc) ? done_dp : done_tc;
            cycles++;
            if (other) begin
                stop_on_error("done pulsed for the requester that was not served");
            end
            if (!seen && cycles >= wait_limit) begin
                stop_on_error("timeout waiting for done");
            end
        end
    endtask

    task automatic run_txn(input requester_t who, input cmd_kind_t kind,
                           input addr_t addr, input length_t length, input data_t wdata);
        drive_request(who, kind, addr, length, wdata);
        wait_ack(who);
        wait_done(who);
    endtask

    task automatic apply_reset();
        reset_n = 1'b0;
        repeat (4) @(negedge clk);
        // Expect request flags low and LocalLink ready and framing high
        check_value("control outputs",
                    {rd_req, wr_req, ack_tc, ack_dp, done_tc, done_dp, rcv_buf_we,
                     rd_dst_rdy_n, wr_src_rdy_n, wr_sof_n, wr_eof_n},
                    11'b000_0000_1111);
        reset_n = 1'b1;
    endtask

    // One pass over every transaction kind at word offset ofs
    task automatic run_phase(input int ofs);
        data_t wdata;
        wdata = 32'hc001_d00d ^ ofs;
        wr_beats_exp = 1;
        run_txn(req_dp, single_wr, addr_t'((16 + ofs) * 4), 4, wdata);
        check_value("u_slave.mem single write", u_slave.mem[16 + ofs], wdata);

        run_txn(req_tc, single_rd, addr_t'((32 + ofs) * 4), 4, '0);
        check_value("single_read_data", single_read_data, u_slave.mem[32 + ofs]);

        wr_beats_exp = 16;
        run_txn(req_tc, burst_wr, addr_t'((64 + ofs) * 4), 64, '0);
        for (int k = 0; k < 16; k++) begin
            check_value("u_slave.mem burst write", u_slave.mem[64 + ofs + k],
                        u_slave.send_mem[k]);
        end

        for (int k = 0; k < 16; k++) begin
            u_slave.rcv_mem[k] = '0;
        end
        run_txn(req_dp, burst_rd, addr_t'((128 + ofs) * 4), 48, '0);
        for (int k = 0; k < 12; k++) begin
            check_value("u_slave.rcv_mem", u_slave.rcv_mem[k], u_slave.mem[128 + ofs + k]);
        end

        // Both requesters start together and tc has priority
        wr_beats_exp = 1;
        drive_request(req_tc, single_rd, addr_t'((200 + ofs) * 4), 4, '0);
        drive_request(req_dp, single_wr, addr_t'((210 + ofs) * 4), 4, ~wdata);
        wait_ack(req_tc);
        wait_done(req_tc);
        check_value("single_read_data", single_read_data, u_slave.mem[200 + ofs]);
        wait_ack(req_dp);
        wait_done(req_dp);
        check_value("u_slave.mem single write", u_slave.mem[210 + ofs], ~wdata);
    endtask

    initial begin
        reset_n      = 1'b0;
        stall_en     = 1'b0;
        wr_beats_exp = 1;
        drive_request(req_tc, single_rd, '0, '0, '0);
        drive_request(req_dp, single_rd, '0, '0, '0);
        start_tc     = 1'b0;
        start_dp     = 1'b0;

        apply_reset();
        run_phase(0);

        // Same pass with random stalls and delayed cmplt
        apply_reset();
        stall_en = 1'b1;
        run_phase(3);

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- all.f
hw/ipic_bus_pkg.sv
hw/ipic_cmd_pkg.sv
hw/ipic_request_arbiter.sv
hw/ipic_command_sequencer.sv
hw/ipic_read_receiver.sv
hw/ipic_write_sender.sv
hw/ipic_master.sv
tests/ipic_slave_model.sv
tests/tb_ipic_master.sv
